// File: build.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/mmio_pkg.sv
hdl/uart_transmitter.sv
hdl/uart_receiver.sv
hdl/uart.sv
hdl/io_interface.sv
hdl/io_subsystem.sv
tb/io_checker.sv
tb/tb_io_subsystem.sv

// File: hdl/io_interface.sv
`timescale 1ns/1ps

`include "uart_consts.svh"

module io_interface
    import mmio_pkg::*, uart_pkg::*;
(
    input  logic       Clock,
    input  logic       rst_n,
    input  bus_addr_t  addr,
    input  bus_word_t  write_data,
    input  logic       io_trans,
    input  logic       io_read,
    output bus_word_t  received,
    output uart_byte_t tx_data,
    output logic       tx_valid,
    input  logic       tx_ready,
    input  uart_byte_t rx_data,
    input  logic       rx_valid,
    output logic       rx_ready
);

    io_reg_t   reg_sel;
    bus_word_t read_word;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    always_comb
    begin
        case (addr)
            `IO_ADDR_STATUS:  reg_sel = REG_STATUS;
            `IO_ADDR_RX_DATA: reg_sel = REG_RX_DATA;
            `IO_ADDR_TX_DATA: reg_sel = REG_TX_DATA;
            default:          reg_sel = REG_NONE;
        endcase
    end

    // ------------------------------------------------------------
    // UART strobes
    // ------------------------------------------------------------

    // Only the low byte of the write word is sent
    assign tx_data  = write_data[7:0];
    assign tx_valid = io_trans && (reg_sel == REG_TX_DATA);

    // Pop only when a byte is actually held
    assign rx_ready = io_read && (reg_sel == REG_RX_DATA) && rx_valid;

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------
    always_comb
    begin
        read_word = '0;
        case (reg_sel)
            REG_STATUS:
            begin
                read_word[STATUS_TX_READY_BIT] = tx_ready;
                read_word[STATUS_RX_VALID_BIT] = rx_valid;
            end
            REG_RX_DATA:
            begin
                if (rx_valid)
                    read_word[7:0] = rx_data;
            end
            default:
            begin
                // Write-only and unmapped addresses read as zero
                read_word = '0;
            end
        endcase
    end

    // Answer appears the cycle after the strobe and holds until the next read
    always_ff @(posedge Clock or negedge rst_n)
    begin
        if (!rst_n)
            received <= '0;
        else if (io_read)
            received <= read_word;
    end

    a_one_strobe: assert property (@(posedge Clock) disable iff (!rst_n)
        !(io_read && io_trans))
        else $error("error io_read and io_trans asserted together");

endmodule

// File: hdl/io_subsystem.sv
`timescale 1ns/1ps

module io_subsystem
    import mmio_pkg::*, uart_pkg::*;
(
    input  logic      Clock,
    input  logic      rst_n,
    input  bus_addr_t addr,
    input  bus_word_t write_data,
    input  logic      io_trans,
    input  logic      io_read,
    output bus_word_t received,
    input  logic      serial_in,
    output logic      serial_out
);

    // ------------------------------------------------------------
    // Internal UART handshake
    // ------------------------------------------------------------
    uart_byte_t tx_data;
    logic       tx_valid;
    logic       tx_ready;
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       rx_ready;

    io_interface u_io (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .addr       (addr),
        .write_data (write_data),
        .io_trans   (io_trans),
        .io_read    (io_read),
        .received   (received),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready)
    );

    uart u_uart (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

endmodule

// File: hdl/mmio_pkg.sv
package mmio_pkg;

    // ------------------------------------------------------------
    // Bus side types
    // ------------------------------------------------------------

    // CPU data word
    typedef logic [31:0] bus_word_t;

    // CPU byte address
    typedef logic [31:0] bus_addr_t;

    // Decoded register select
    typedef enum logic [1:0]
    {
        REG_NONE    = 2'd0,
        REG_STATUS  = 2'd1,
        REG_RX_DATA = 2'd2,
        REG_TX_DATA = 2'd3
    } io_reg_t;

    // Status bit positions
    localparam int STATUS_TX_READY_BIT = 0;
    localparam int STATUS_RX_VALID_BIT = 1;

endpackage

// File: hdl/uart.sv
`timescale 1ns/1ps

module uart
    import uart_pkg::*;
(
    input  logic       Clock,
    input  logic       rst_n,
    input  uart_byte_t tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output uart_byte_t rx_data,
    output logic       rx_valid,
    input  logic       rx_ready,
    input  logic       serial_in,
    output logic       serial_out
);

    uart_byte_t frame_data;
    logic       frame_done;
    logic       load;

    uart_transmitter u_tx (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    uart_receiver u_rx (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .serial_in  (serial_in),
        .frame_data (frame_data),
        .frame_done (frame_done)
    );

    // ------------------------------------------------------------
    // One-byte receive buffer
    // ------------------------------------------------------------

    // New frame only lands in an empty buffer, otherwise dropped
    assign load = frame_done && !rx_valid;

    always_ff @(posedge Clock or negedge rst_n)
    begin
        if (!rst_n)
            rx_valid <= 1'b0;
        else if (load)
            rx_valid <= 1'b1;
        else if (rx_ready)
            rx_valid <= 1'b0;
    end

    always_ff @(posedge Clock)
    begin
        if (load)
            rx_data <= frame_data;
    end

    // Consumer side must only pop a held byte
    a_ready_needs_valid: assert property (@(posedge Clock) disable iff (!rst_n)
        rx_ready |-> rx_valid)
        else $error("error rx_ready without rx_valid");

endmodule

// File: hdl/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// ------------------------------------------------------------
// Serial timing
// ------------------------------------------------------------

// Clocks per serial bit, fixed bit period
`define UART_CLKS_PER_BIT 8

// Start + 8 data + stop
`define UART_FRAME_BITS 10

// ------------------------------------------------------------
// Memory-mapped register addresses
// ------------------------------------------------------------

`define IO_ADDR_STATUS  32'h80000000
`define IO_ADDR_RX_DATA 32'h80000004
`define IO_ADDR_TX_DATA 32'h80000008

`endif

// File: hdl/uart_pkg.sv
package uart_pkg;

    // ------------------------------------------------------------
    // Serial side types
    // ------------------------------------------------------------

    // One data byte on the line
    typedef logic [7:0] uart_byte_t;

    // Transmitter FSM
    typedef enum logic [1:0]
    {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

    // Receiver FSM
    typedef enum logic [1:0]
    {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_t;

endpackage

// File: hdl/uart_receiver.sv
`timescale 1ns/1ps

`include "uart_consts.svh"

module uart_receiver
    import uart_pkg::*;
(
    input  logic       Clock,
    input  logic       rst_n,
    input  logic       serial_in,
    output uart_byte_t frame_data,
    output logic       frame_done
);

    localparam int CLKS      = `UART_CLKS_PER_BIT;
    localparam int HALF      = (CLKS > 1) ? CLKS / 2 : 1;
    localparam int CNT_W     = (CLKS > 1) ? $clog2(CLKS) : 1;
    localparam int DATA_BITS = `UART_FRAME_BITS - 2;

    logic [1:0]       sync_q;
    logic             rx_sync;
    logic             rx_prev;
    rx_state_t        state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic             half_end;
    logic             bit_end;

    // ------------------------------------------------------------
    // Input synchronizer, held high in reset like an idle line
    // ------------------------------------------------------------
    always_ff @(posedge Clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end
        else
        begin
            sync_q  <= {sync_q[0], serial_in};
            rx_prev <= sync_q[1];
        end
    end

    assign rx_sync  = sync_q[1];
    assign half_end = (bit_cnt == CNT_W'(HALF - 1));
    assign bit_end  = (bit_cnt == CNT_W'(CLKS - 1));

    // ------------------------------------------------------------
    // Frame FSM
    // ------------------------------------------------------------
    always_ff @(posedge Clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= RX_IDLE;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            case (state)
                RX_IDLE:
                begin
                    bit_cnt <= '0;
                    // Falling edge marks a candidate start bit
                    if (rx_prev && !rx_sync)
                        state <= RX_START;
                end
                RX_START:
                begin
                    if (half_end)
                    begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch if the line went back high
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                RX_DATA:
                begin
                    if (bit_end)
                    begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'(DATA_BITS - 1))
                            state <= RX_STOP;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                RX_STOP:
                begin
                    if (bit_end)
                    begin
                        bit_cnt    <= '0;
                        state      <= RX_IDLE;
                        frame_done <= rx_sync;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                default:
                begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Mid-bit sample, LSB arrives first
    always_ff @(posedge Clock)
    begin
        if (state == RX_DATA && bit_end)
            frame_data <= {rx_sync, frame_data[7:1]};
    end

    a_done_pulse: assert property (@(posedge Clock) disable iff (!rst_n)
        frame_done |=> !frame_done)
        else $error("error frame_done held for more than one cycle");

endmodule

// File: hdl/uart_transmitter.sv
`timescale 1ns/1ps

`include "uart_consts.svh"

module uart_transmitter
    import uart_pkg::*;
(
    input  logic       Clock,
    input  logic       rst_n,
    input  uart_byte_t tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       serial_out
);

    localparam int CLKS      = `UART_CLKS_PER_BIT;
    localparam int CNT_W     = (CLKS > 1) ? $clog2(CLKS) : 1;
    localparam int DATA_BITS = `UART_FRAME_BITS - 2;

    tx_state_t        state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shift_q;
    logic             bit_end;
    logic             accept;

    assign tx_ready = (state == TX_IDLE);
    assign accept   = tx_valid && tx_ready;
    assign bit_end  = (bit_cnt == CNT_W'(CLKS - 1));

    // ------------------------------------------------------------
    // Frame FSM
    // ------------------------------------------------------------
    always_ff @(posedge Clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= TX_IDLE;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            serial_out <= 1'b1;
        end
        else
        begin
            if (state != TX_IDLE)
                bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;

            case (state)
                TX_IDLE:
                begin
                    if (accept)
                    begin
                        // Start bit goes out on the next cycle
                        state      <= TX_START;
                        bit_cnt    <= '0;
                        serial_out <= 1'b0;
                    end
                end
                TX_START:
                begin
                    if (bit_end)
                    begin
                        state      <= TX_DATA;
                        bit_idx    <= '0;
                        serial_out <= shift_q[0];
                    end
                end
                TX_DATA:
                begin
                    if (bit_end)
                    begin
                        if (bit_idx == 3'(DATA_BITS - 1))
                        begin
                            state      <= TX_STOP;
                            serial_out <= 1'b1;
                        end
                        else
                        begin
                            bit_idx    <= bit_idx + 1'b1;
                            serial_out <= shift_q[0];
                        end
                    end
                end
                TX_STOP:
                begin
                    if (bit_end)
                        state <= TX_IDLE;
                end
                default:
                begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Byte latch and LSB-first shifter
    always_ff @(posedge Clock)
    begin
        if (accept)
            shift_q <= tx_data;
        else if (bit_end && (state == TX_START || state == TX_DATA))
            shift_q <= shift_q >> 1;
    end

    // Line must idle high whenever no frame is in progress
    a_idle_high: assert property (@(posedge Clock) disable iff (!rst_n)
        (state == TX_IDLE) |-> serial_out)
        else $error("error serial_out low while transmitter idle");

endmodule

// File: tb/io_checker.sv
`timescale 1ns/1ps

`include "uart_consts.svh"

module io_checker
    import mmio_pkg::*, uart_pkg::*;
(
    input  logic      Clock,
    input  logic      rst_n,
    input  bus_addr_t addr,
    input  bus_word_t write_data,
    input  logic      io_trans,
    input  logic      io_read,
    input  bus_word_t received,
    input  logic      serial_in,
    input  logic      serial_out,
    output int        error_count,
    output logic      quiet
);

    localparam int CLKS       = `UART_CLKS_PER_BIT;
    localparam int FRAME_BITS = `UART_FRAME_BITS;
    localparam int FRAME_CLKS = FRAME_BITS * CLKS;
    localparam int MID        = CLKS / 2;
    // Mid stop bit, two synchronizer flops, start edge register and buffer register
    localparam int RX_LATENCY = (FRAME_BITS - 1) * CLKS + MID + 4;

    // Transmit side model
    int                    busy_cnt;
    logic                  tx_ready_m;
    logic                  start_due;
    uart_byte_t            tx_expect[$];
    uart_byte_t            tx_byte;
    logic                  tx_active;
    int                    tx_t;
    logic [FRAME_BITS-1:0] tx_bits;
    logic                  out_prev;

    // Receive side model
    logic                  rx_active;
    int                    rx_t;
    logic [FRAME_BITS-1:0] rx_bits;
    logic                  in_prev;
    logic                  held;
    uart_byte_t            held_byte;
    logic                  load;
    logic                  pop;

    // Bus read model
    logic                  read_due;
    bus_word_t             read_expect;

    initial
        error_count = 0;

    task automatic fail_value(input string name, input logic [31:0] expected,
                              input logic [31:0] got);
        error_count++;
        $display("error %s: expected %h, got %h at %0t", name, expected, got, $time);
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("%s at %0t", msg, $time);
    endtask

    always @(posedge Clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy_cnt    = 0;
            start_due   = 1'b0;
            tx_expect.delete();
            tx_active   = 1'b0;
            tx_t        = 0;
            out_prev    = 1'b1;
            rx_active   = 1'b0;
            rx_t        = 0;
            in_prev     = 1'b1;
            held        = 1'b0;
            held_byte   = '0;
            read_due    = 1'b0;
            read_expect = '0;
            quiet       = 1'b1;
        end
        else
        begin
            // Last read answer, zero out of reset and held until the next read
            if (received !== read_expect)
                fail_value("received", read_expect, received);
            read_due = 1'b0;

            // ------------------------------------------------------------
            // Transmit side
            // ------------------------------------------------------------
            tx_ready_m = (busy_cnt == 0);
            if (start_due)
            begin
                if (serial_out !== 1'b0)
                    fail_value("serial_out", 32'h0, serial_out);
            end
            else if (tx_ready_m && !tx_active && serial_out !== 1'b1)
                fail_value("serial_out", 32'h1, serial_out);
            start_due = 1'b0;

            if (!tx_active && out_prev && !serial_out)
            begin
                tx_active = 1'b1;
                tx_t      = 0;
            end
            else if (tx_active)
                tx_t++;
            if (tx_active && (tx_t % CLKS) == MID)
                tx_bits[tx_t / CLKS] = serial_out;
            if (tx_active && tx_t == (FRAME_BITS - 1) * CLKS + MID)
            begin
                tx_active = 1'b0;
                if (tx_expect.size() == 0)
                    report_problem("frame on serial_out without an accepted write");
                else
                begin
                    tx_byte = tx_expect.pop_front();
                    if (tx_bits[8:1] !== tx_byte)
                        fail_value("serial_out data byte", tx_byte, tx_bits[8:1]);
                end
                if (tx_bits[0] !== 1'b0)
                    report_problem("start bit on serial_out was high at mid bit");
                if (tx_bits[FRAME_BITS-1] !== 1'b1)
                    report_problem("stop bit on serial_out was low");
            end

            // A write is taken only while the transmitter is free
            if (io_trans && addr == `IO_ADDR_TX_DATA && tx_ready_m)
            begin
                tx_expect.push_back(write_data[7:0]);
                busy_cnt  = FRAME_CLKS;
                start_due = 1'b1;
            end
            else if (busy_cnt > 0)
                busy_cnt--;

            // ------------------------------------------------------------
            // Receive side and bus reads
            // ------------------------------------------------------------
            if (!rx_active && in_prev && !serial_in)
            begin
                rx_active = 1'b1;
                rx_t      = 0;
            end
            else if (rx_active)
                rx_t++;
            if (rx_active && (rx_t % CLKS) == MID && rx_t < FRAME_CLKS)
                rx_bits[rx_t / CLKS] = serial_in;

            pop = 1'b0;
            if (io_read)
            begin
                read_due    = 1'b1;
                read_expect = '0;
                if (addr == `IO_ADDR_STATUS)
                begin
                    read_expect[0] = tx_ready_m;
                    read_expect[1] = held;
                end
                else if (addr == `IO_ADDR_RX_DATA && held)
                begin
                    read_expect[7:0] = held_byte;
                    pop              = 1'b1;
                end
            end

            // Frame lands only in an empty buffer and only with a high stop bit
            load = 1'b0;
            if (rx_active && rx_t == RX_LATENCY - 1)
            begin
                rx_active = 1'b0;
                load      = rx_bits[FRAME_BITS-1] && !held;
            end
            if (load)
            begin
                held      = 1'b1;
                held_byte = rx_bits[8:1];
            end
            else if (pop)
                held = 1'b0;

            out_prev = serial_out;
            in_prev  = serial_in;
            quiet    = (busy_cnt == 0) && !tx_active && !rx_active && !read_due
                       && (tx_expect.size() == 0);
        end
    end

endmodule

// File: tb/tb_io_subsystem.sv
`timescale 1ns/1ps

`include "uart_consts.svh"

module tb_io_subsystem
    import mmio_pkg::*, uart_pkg::*;
();

    localparam int CLK_PERIOD_NS = 4;
    localparam int CLKS          = `UART_CLKS_PER_BIT;
    localparam int FRAME_CLKS    = `UART_FRAME_BITS * CLKS;
    localparam int MIX_FRAMES    = 12;
    localparam int MIX_OPS       = 40;
    // Idle gaps take 6 random bits
    localparam int MAX_GAP       = 64;
    // Directed frames first, then every mixed frame and write
    localparam int MAX_FRAMES    = 8 + MIX_FRAMES + MIX_OPS;
    localparam int WATCHDOG_CYCLES = MAX_FRAMES * (FRAME_CLKS + MAX_GAP) + 1000;

    logic       Clock;
    logic       rst_n;
    bus_addr_t  addr;
    bus_word_t  write_data;
    logic       io_trans;
    logic       io_read;
    bus_word_t  received;
    logic       serial_in;
    logic       serial_out;
    int         error_count;
    logic       quiet;

    logic [31:0] lfsr_state;
    int          tests_run;
    int          tests_bad;
    int          errors_seen;
    uart_byte_t  rx_byte;

    uart_byte_t  mix_byte[MIX_FRAMES];
    int          mix_gap[MIX_FRAMES];
    logic [1:0]  mix_op[MIX_OPS];
    bus_word_t   mix_word[MIX_OPS];
    int          mix_wait[MIX_OPS];

    io_subsystem dut (
        .Clock      (Clock),
        .rst_n      (rst_n),
        .addr       (addr),
        .write_data (write_data),
        .io_trans   (io_trans),
        .io_read    (io_read),
        .received   (received),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

    io_checker u_checker (
        .Clock       (Clock),
        .rst_n       (rst_n),
        .addr        (addr),
        .write_data  (write_data),
        .io_trans    (io_trans),
        .io_read     (io_read),
        .received    (received),
        .serial_in   (serial_in),
        .serial_out  (serial_out),
        .error_count (error_count),
        .quiet       (quiet)
    );

    always #(CLK_PERIOD_NS / 2) Clock = ~Clock;

    // ------------------------------------------------------------
    // Random numbers, taps 32 22 2 1
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // ------------------------------------------------------------
    // Bus and serial drivers
    // ------------------------------------------------------------
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge Clock);
    endtask

    task automatic bus_read(input bus_addr_t a);
        @(posedge Clock);
        addr    <= a;
        io_read <= 1'b1;
        @(posedge Clock);
        io_read <= 1'b0;
    endtask

    task automatic bus_write(input bus_addr_t a, input bus_word_t d);
        @(posedge Clock);
        addr       <= a;
        write_data <= d;
        io_trans   <= 1'b1;
        @(posedge Clock);
        io_trans <= 1'b0;
    endtask

    task automatic bus_op(input logic [1:0] op, input bus_word_t w);
        case (op)
            2'd0:    bus_read(`IO_ADDR_STATUS);
            2'd1:    bus_read(`IO_ADDR_RX_DATA);
            2'd2:    bus_write(`IO_ADDR_TX_DATA, w);
            default: bus_read(w);
        endcase
    endtask

    // One 8N1 frame, a low stop_bit makes a framing error
    task automatic send_frame(input uart_byte_t b, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, b, 1'b0};
        for (int i = 0; i < `UART_FRAME_BITS; i++)
        begin
            @(posedge Clock);
            serial_in <= bits[i];
            idle_cycles(CLKS - 1);
        end
        @(posedge Clock);
        serial_in <= 1'b1;
    endtask

    task automatic wait_settled();
        repeat (2) @(negedge Clock);
        while (!quiet)
            @(negedge Clock);
    endtask

    task automatic end_test(input string name);
        int errs;
        wait_settled();
        errs        = error_count - errors_seen;
        errors_seen = error_count;
        tests_run++;
        if (errs == 0)
            $display("[%s] ok", name);
        else
        begin
            tests_bad++;
            $display("[%s] %0d errors", name, errs);
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin
        Clock       = 1'b0;
        rst_n       = 1'b0;
        addr        = '0;
        write_data  = '0;
        io_trans    = 1'b0;
        io_read     = 1'b0;
        serial_in   = 1'b1;
        lfsr_state  = 32'h240ff711;
        tests_run   = 0;
        tests_bad   = 0;
        errors_seen = 0;
        repeat (5) @(posedge Clock);
        rst_n <= 1'b1;
        idle_cycles(2);

        bus_read(`IO_ADDR_STATUS);
        end_test("reset_status");

        repeat (3)
        begin
            bus_write(`IO_ADDR_TX_DATA, rand_bits(32));
            wait_settled();
        end
        end_test("tx_frames");

        // Second write hits a busy transmitter
        bus_write(`IO_ADDR_TX_DATA, rand_bits(32));
        idle_cycles(1 + rand_bits(5));
        bus_write(`IO_ADDR_TX_DATA, rand_bits(32));
        bus_read(`IO_ADDR_STATUS);
        end_test("tx_busy_drop");

        send_frame(8'(rand_bits(8)), 1'b1);
        wait_settled();
        bus_read(`IO_ADDR_STATUS);
        bus_read(`IO_ADDR_RX_DATA);
        bus_read(`IO_ADDR_STATUS);
        // Third frame arrives while the second is still held
        rx_byte = 8'(rand_bits(8));
        send_frame(rx_byte, 1'b1);
        idle_cycles(4);
        send_frame(~rx_byte, 1'b1);
        wait_settled();
        bus_read(`IO_ADDR_RX_DATA);
        bus_read(`IO_ADDR_RX_DATA);
        bus_read(`IO_ADDR_STATUS);
        end_test("rx_hold");

        send_frame(8'(rand_bits(8)), 1'b0);
        wait_settled();
        bus_read(`IO_ADDR_STATUS);
        bus_read(`IO_ADDR_RX_DATA);
        end_test("rx_bad_stop");

        repeat (6)
            bus_read(rand_bits(32));
        bus_read(`IO_ADDR_TX_DATA);
        bus_read(`IO_ADDR_RX_DATA);
        end_test("unmapped_reads");

        // Drawn up front so both processes below stay independent of LFSR order
        for (int i = 0; i < MIX_FRAMES; i++)
        begin
            mix_byte[i] = 8'(rand_bits(8));
            mix_gap[i]  = 1 + rand_bits(6);
        end
        for (int j = 0; j < MIX_OPS; j++)
        begin
            mix_op[j]   = 2'(rand_bits(2));
            mix_word[j] = rand_bits(32);
            mix_wait[j] = rand_bits(4);
        end
        fork
            begin
                for (int i = 0; i < MIX_FRAMES; i++)
                begin
                    send_frame(mix_byte[i], 1'b1);
                    idle_cycles(mix_gap[i]);
                end
            end
            begin
                for (int j = 0; j < MIX_OPS; j++)
                begin
                    bus_op(mix_op[j], mix_word[j]);
                    idle_cycles(mix_wait[j]);
                end
            end
        join
        end_test("mixed_traffic");

        $display("tests run %0d, with errors %0d, total errors %0d",
                 tests_run, tests_bad, error_count);
        if (tests_bad == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // Bounded by the worst case frame count
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles, bus or serial traffic never settled",
                 WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule
